// ==== hw/vec_issue_cfg.svh ====
/*
 * Vector issue front end configuration
 * Queue depth and the widths of the instruction and the core's id
 */

`ifndef VEC_ISSUE_CFG_SVH
`define VEC_ISSUE_CFG_SVH

// Entries held between the core and the sequencer
`define VI_QUEUE_DEPTH 16

// Instruction word offered by the scalar core
`define VI_INSN_W 32

// Instruction id tag of the core
`define VI_ID_W 4

`endif

// ==== hw/vec_isa_pkg.sv ====
/*
 * Vector ISA encodings
 * Opcodes, width and funct3 fields, and the class and operand source enums
 */

`default_nettype none

package vec_isa_pkg;

  // Major opcodes
  localparam logic [6:0] OPC_OP_V     = 7'b1010111;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  // OP-V funct3 categories
  localparam logic [2:0] F3_OPIVV   = 3'b000;
  localparam logic [2:0] F3_OPFVV   = 3'b001;
  localparam logic [2:0] F3_OPMVV   = 3'b010;
  localparam logic [2:0] F3_OPIVI   = 3'b011;
  localparam logic [2:0] F3_OPIVX   = 3'b100;
  localparam logic [2:0] F3_OPFVF   = 3'b101;
  localparam logic [2:0] F3_OPMVX   = 3'b110;
  localparam logic [2:0] FUNCT3_CFG = 3'b111;

  // Vector element widths of loads and stores
  localparam logic [2:0] WIDTH_E8  = 3'b000;
  localparam logic [2:0] WIDTH_E16 = 3'b101;
  localparam logic [2:0] WIDTH_E32 = 3'b110;
  localparam logic [2:0] WIDTH_E64 = 3'b111;

  // vmv.x.s, vcpop and vfirst share this funct6 under OPMVV
  localparam logic [5:0] FUNCT6_VWXUNARY = 6'b010000;
  // Upper funct6 bits of the multiply-add group
  localparam logic [2:0] FUNCT6_MADD_HI  = 3'b101;

  typedef enum logic [1:0] {
    CLS_ARITH = 2'd0,
    CLS_LOAD  = 2'd1,
    CLS_STORE = 2'd2,
    CLS_CFG   = 2'd3
  } insn_class_e;

  typedef enum logic [1:0] {
    SRC_VEC    = 2'd0,
    SRC_SCALAR = 2'd1,
    SRC_IMM    = 2'd2,
    SRC_NONE   = 2'd3
  } src_kind_e;

endpackage

`default_nettype wire

// ==== hw/vec_issue_pkg.sv ====
/*
 * Issue path types
 * Widths of instruction, id, register index and queue fill count
 */

`default_nettype none

`include "vec_issue_cfg.svh"

package vec_issue_pkg;

  // Raw instruction word from the core
  typedef logic [`VI_INSN_W-1:0] insn_t;

  // Core instruction id, returned with every queue entry
  typedef logic [`VI_ID_W-1:0] insn_id_t;

  // One of the 32 architectural vector registers
  typedef logic [4:0] vreg_t;

  // Fill count, has to reach the full depth
  typedef logic [$clog2(`VI_QUEUE_DEPTH+1)-1:0] usage_t;

endpackage

`default_nettype wire

// ==== hw/vec_insn_classifier.sv ====
/*
 * Instruction classifier
 * Decides whether an offered word is a vector instruction, gives its class
 * and flags the ones that owe a scalar result to the core
 */

`timescale 1ns/1ps
`default_nettype none

module vec_insn_classifier (
  input  vec_issue_pkg::insn_t     insn_i,
  output logic                     accept_o,
  output vec_isa_pkg::insn_class_e class_o,
  output logic                     writeback_o
);

  import vec_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       width_ok;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct6 = insn_i[31:26];

  // Memory width field sits where funct3 is
  assign width_ok = (funct3 == WIDTH_E8)  || (funct3 == WIDTH_E16) ||
                    (funct3 == WIDTH_E32) || (funct3 == WIDTH_E64);

  always_comb begin
    accept_o    = 1'b0;
    class_o     = CLS_ARITH;
    writeback_o = 1'b0;

    case (opcode)
      OPC_OP_V: begin
        accept_o = 1'b1;
        if (funct3 == FUNCT3_CFG) begin
          // vsetvl family returns the new vl
          class_o     = CLS_CFG;
          writeback_o = 1'b1;
        end else begin
          class_o     = CLS_ARITH;
          writeback_o = (funct3 == F3_OPMVV) && (funct6 == FUNCT6_VWXUNARY);
        end
      end
      OPC_LOAD_FP: begin
        accept_o = width_ok;
        class_o  = CLS_LOAD;
      end
      OPC_STORE_FP: begin
        accept_o = width_ok;
        class_o  = CLS_STORE;
      end
      default: begin
        accept_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/vec_pre_decoder.sv ====
/*
 * Vector pre-decoder
 * Pulls the register fields and the mask bit out of an offered word,
 * maps funct3 to an operand source and marks a read of the destination
 */

`timescale 1ns/1ps
`default_nettype none

module vec_pre_decoder (
  input  vec_issue_pkg::insn_t   insn_i,
  output vec_issue_pkg::vreg_t   vd_o,
  output vec_issue_pkg::vreg_t   vs1_o,
  output vec_issue_pkg::vreg_t   vs2_o,
  output vec_isa_pkg::src_kind_e src_kind_o,
  output logic                   vm_o,
  output logic                   reads_vd_o
);

  import vec_isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       madd_op;
  logic       store_op;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct6 = insn_i[31:26];

  ////////////////////////////////////////////////////////////////////////////
  // Register fields

  assign vd_o  = insn_i[11:7];
  assign vs1_o = insn_i[19:15];
  assign vs2_o = insn_i[24:20];
  // Low means masked by v0
  assign vm_o  = insn_i[25];

  ////////////////////////////////////////////////////////////////////////////
  // Operand source

  always_comb begin
    case (funct3)
      F3_OPIVV, F3_OPFVV, F3_OPMVV: src_kind_o = SRC_VEC;
      F3_OPIVI:                     src_kind_o = SRC_IMM;
      F3_OPIVX, F3_OPFVF, F3_OPMVX: src_kind_o = SRC_SCALAR;
      default:                      src_kind_o = SRC_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Destination read

  // Multiply-adds accumulate into vd, integer and float forms alike
  assign madd_op = (funct6[5:3] == FUNCT6_MADD_HI) &&
                   ((funct3 == F3_OPMVV) || (funct3 == F3_OPMVX) ||
                    (funct3 == F3_OPFVV) || (funct3 == F3_OPFVF));

  // Store data register vs3 lives in the vd field
  assign store_op = (opcode == OPC_STORE_FP);

  assign reads_vd_o = madd_op || store_op;

endmodule

`default_nettype wire

// ==== hw/vec_issue_queue.sv ====
/*
 * Vector issue queue
 * Circular buffer of combined decode results, filled from the core's issue
 * handshake and drained in order by the sequencer; flush empties it
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_issue_cfg.svh"

module vec_issue_queue #(
  parameter int unsigned DEPTH = `VI_QUEUE_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Core side
  input  logic                     issue_valid_i,
  input  vec_issue_pkg::insn_id_t  issue_id_i,
  input  logic                     accept_i,
  input  vec_isa_pkg::insn_class_e class_i,
  input  vec_issue_pkg::vreg_t     vd_i,
  input  vec_issue_pkg::vreg_t     vs1_i,
  input  vec_issue_pkg::vreg_t     vs2_i,
  input  vec_isa_pkg::src_kind_e   src_kind_i,
  input  logic                     vm_i,
  input  logic                     reads_vd_i,
  output logic                     issue_ready_o,
  // Sequencer side
  output logic                     seq_valid_o,
  input  logic                     seq_ready_i,
  output vec_issue_pkg::insn_id_t  seq_id_o,
  output vec_isa_pkg::insn_class_e seq_class_o,
  output vec_issue_pkg::vreg_t     seq_vd_o,
  output vec_issue_pkg::vreg_t     seq_vs1_o,
  output vec_issue_pkg::vreg_t     seq_vs2_o,
  output vec_isa_pkg::src_kind_e   seq_src_kind_o,
  output logic                     seq_vm_o,
  output logic                     seq_reads_vd_o,
  output vec_issue_pkg::usage_t    usage_o
);

  import vec_isa_pkg::*;
  import vec_issue_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  typedef logic [PTR_W-1:0] ptr_t;

  insn_id_t    id_q       [DEPTH];
  insn_class_e class_q    [DEPTH];
  vreg_t       vd_q       [DEPTH];
  vreg_t       vs1_q      [DEPTH];
  vreg_t       vs2_q      [DEPTH];
  src_kind_e   src_kind_q [DEPTH];
  logic        vm_q       [DEPTH];
  logic        reads_vd_q [DEPTH];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  usage_t count_q;
  logic   full;
  logic   push;
  logic   pop;

  // Wraps also for depths that are no power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes

  assign full          = (count_q == usage_t'(DEPTH));
  assign issue_ready_o = issue_valid_i && !full && !flush_i;
  // Rejected offers complete the handshake without a slot
  assign push          = issue_valid_i && issue_ready_o && accept_i;
  assign seq_valid_o   = (count_q != '0);
  assign pop           = seq_valid_o && seq_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Entry storage

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_ptr_q]       <= issue_id_i;
      class_q[wr_ptr_q]    <= class_i;
      vd_q[wr_ptr_q]       <= vd_i;
      vs1_q[wr_ptr_q]      <= vs1_i;
      vs2_q[wr_ptr_q]      <= vs2_i;
      src_kind_q[wr_ptr_q] <= src_kind_i;
      vm_q[wr_ptr_q]       <= vm_i;
      reads_vd_q[wr_ptr_q] <= reads_vd_i;
    end
  end

  // Head entry
  assign seq_id_o       = id_q[rd_ptr_q];
  assign seq_class_o    = class_q[rd_ptr_q];
  assign seq_vd_o       = vd_q[rd_ptr_q];
  assign seq_vs1_o      = vs1_q[rd_ptr_q];
  assign seq_vs2_o      = vs2_q[rd_ptr_q];
  assign seq_src_kind_o = src_kind_q[rd_ptr_q];
  assign seq_vm_o       = vm_q[rd_ptr_q];
  assign seq_reads_vd_o = reads_vd_q[rd_ptr_q];
  assign usage_o        = count_q;

endmodule

`default_nettype wire

// ==== hw/vec_issue_top.sv ====
/*
 * Vector issue front end
 * Classifier and pre-decoder side by side on the offered instruction,
 * feeding the issue queue towards the sequencer
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_issue_cfg.svh"

module vec_issue_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Core issue interface
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  vec_issue_pkg::insn_t     issue_instr_i,
  input  vec_issue_pkg::insn_id_t  issue_id_i,
  output logic                     issue_accept_o,
  output logic                     issue_writeback_o,
  // Sequencer interface
  output logic                     seq_valid_o,
  input  logic                     seq_ready_i,
  output vec_issue_pkg::insn_id_t  seq_id_o,
  output vec_isa_pkg::insn_class_e seq_class_o,
  output vec_issue_pkg::vreg_t     seq_vd_o,
  output vec_issue_pkg::vreg_t     seq_vs1_o,
  output vec_issue_pkg::vreg_t     seq_vs2_o,
  output vec_isa_pkg::src_kind_e   seq_src_kind_o,
  output logic                     seq_vm_o,
  output logic                     seq_reads_vd_o,
  output vec_issue_pkg::usage_t    usage_o
);

  import vec_isa_pkg::*;
  import vec_issue_pkg::*;

  // Decode results towards the queue
  insn_class_e insn_class;
  vreg_t       vd;
  vreg_t       vs1;
  vreg_t       vs2;
  src_kind_e   src_kind;
  logic        vm;
  logic        reads_vd;

  vec_insn_classifier i_classifier (
    .insn_i      (issue_instr_i    ),
    .accept_o    (issue_accept_o   ),
    .class_o     (insn_class       ),
    .writeback_o (issue_writeback_o)
  );

  vec_pre_decoder i_pre_decoder (
    .insn_i     (issue_instr_i),
    .vd_o       (vd           ),
    .vs1_o      (vs1          ),
    .vs2_o      (vs2          ),
    .src_kind_o (src_kind     ),
    .vm_o       (vm           ),
    .reads_vd_o (reads_vd     )
  );

  vec_issue_queue #(
    .DEPTH (`VI_QUEUE_DEPTH)
  ) i_queue (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .flush_i        (flush_i       ),
    .issue_valid_i  (issue_valid_i ),
    .issue_id_i     (issue_id_i    ),
    .accept_i       (issue_accept_o),
    .class_i        (insn_class    ),
    .vd_i           (vd            ),
    .vs1_i          (vs1           ),
    .vs2_i          (vs2           ),
    .src_kind_i     (src_kind      ),
    .vm_i           (vm            ),
    .reads_vd_i     (reads_vd      ),
    .issue_ready_o  (issue_ready_o ),
    .seq_valid_o    (seq_valid_o   ),
    .seq_ready_i    (seq_ready_i   ),
    .seq_id_o       (seq_id_o      ),
    .seq_class_o    (seq_class_o   ),
    .seq_vd_o       (seq_vd_o      ),
    .seq_vs1_o      (seq_vs1_o     ),
    .seq_vs2_o      (seq_vs2_o     ),
    .seq_src_kind_o (seq_src_kind_o),
    .seq_vm_o       (seq_vm_o      ),
    .seq_reads_vd_o (seq_reads_vd_o),
    .usage_o        (usage_o       )
  );

endmodule

`default_nettype wire

// ==== tb/vec_issue_chk.sv ====
/*
 * Issue front end port checks
 * Concurrent assertions on the core and sequencer handshakes
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_issue_cfg.svh"

module vec_issue_chk (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     flush_i,
  input logic                     issue_valid_i,
  input logic                     issue_ready_o,
  input logic                     seq_valid_o,
  input logic                     seq_ready_i,
  input vec_issue_pkg::insn_id_t  seq_id_o,
  input vec_isa_pkg::insn_class_e seq_class_o,
  input vec_issue_pkg::vreg_t     seq_vd_o,
  input vec_issue_pkg::vreg_t     seq_vs1_o,
  input vec_issue_pkg::vreg_t     seq_vs2_o,
  input vec_isa_pkg::src_kind_e   seq_src_kind_o,
  input logic                     seq_vm_o,
  input logic                     seq_reads_vd_o,
  input vec_issue_pkg::usage_t    usage_o
);

  import vec_issue_pkg::*;

  // Head entry as one word
  logic [24:0] entry;

  // Number of failed port assertions
  int unsigned fail_cnt = 0;

  assign entry = {seq_id_o, seq_class_o, seq_vd_o, seq_vs1_o, seq_vs2_o,
                  seq_src_kind_o, seq_vm_o, seq_reads_vd_o};

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_ready_o |-> issue_valid_i)
    else begin
      fail_cnt++;
      $error("issue_ready_o high without issue_valid_i");
    end

  flush_blocks_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !issue_ready_o)
    else begin
      fail_cnt++;
      $error("issue_ready_o high during flush");
    end

  flush_empties: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !seq_valid_o && (usage_o == '0))
    else begin
      fail_cnt++;
      $error("queue not empty one cycle after flush");
    end

  usage_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    usage_o <= usage_t'(`VI_QUEUE_DEPTH))
    else begin
      fail_cnt++;
      $error("usage_o above queue depth");
    end

  // Stalled head holds until the sequencer takes it
  head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    seq_valid_o && !seq_ready_i && !flush_i |=> seq_valid_o && $stable(entry))
    else begin
      fail_cnt++;
      $error("sequencer entry changed while stalled");
    end

endmodule

bind vec_issue_top vec_issue_chk i_chk (
  .clk_i          (clk_i         ),
  .rst_n_i        (rst_n_i       ),
  .flush_i        (flush_i       ),
  .issue_valid_i  (issue_valid_i ),
  .issue_ready_o  (issue_ready_o ),
  .seq_valid_o    (seq_valid_o   ),
  .seq_ready_i    (seq_ready_i   ),
  .seq_id_o       (seq_id_o      ),
  .seq_class_o    (seq_class_o   ),
  .seq_vd_o       (seq_vd_o      ),
  .seq_vs1_o      (seq_vs1_o     ),
  .seq_vs2_o      (seq_vs2_o     ),
  .seq_src_kind_o (seq_src_kind_o),
  .seq_vm_o       (seq_vm_o      ),
  .seq_reads_vd_o (seq_reads_vd_o),
  .usage_o        (usage_o       )
);

`default_nettype wire

// ==== tb/tb_vec_issue_top.sv ====
/*
 * Testbench for the vector issue front end
 * Offers random instructions and checks both sides against a model queue
 */

`timescale 1ns/1ps
`default_nettype none

`include "vec_issue_cfg.svh"

module tb_vec_issue_top;

  import vec_isa_pkg::*;
  import vec_issue_pkg::*;

  localparam int DEPTH = `VI_QUEUE_DEPTH;
  localparam int N_CLS = 128;
  localparam int N_ORD = 200;
  localparam int N_REJ = 40;
  // Up to three cycles per offer under random back-pressure, plus drains
  localparam int LIMIT = 3 * (N_CLS + N_ORD + N_REJ + 4 * DEPTH) + 200;

  typedef struct packed {
    insn_id_t    id;
    insn_class_e cls;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    src_kind_e   src;
    logic        vm;
    logic        rvd;
  } entry_t;

  logic        clk, rst_n, flush, issue_valid, seq_ready;
  insn_t       issue_instr;
  insn_id_t    issue_id, seq_id;
  logic        issue_ready, issue_accept, issue_wb, seq_valid, seq_vm, seq_rvd;
  insn_class_e seq_class;
  vreg_t       seq_vd, seq_vs1, seq_vs2;
  src_kind_e   seq_src;
  usage_t      usage, s_usage;

  entry_t model_q[$];
  int     errors, checks, tests, base_errors;
  int     cycle_cnt = 0;
  logic   rand_ready, xfer, s_ready, s_valid;

  vec_issue_top uut (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush),
    .issue_valid_i (issue_valid), .issue_ready_o (issue_ready),
    .issue_instr_i (issue_instr), .issue_id_i (issue_id),
    .issue_accept_o (issue_accept), .issue_writeback_o (issue_wb),
    .seq_valid_o (seq_valid), .seq_ready_i (seq_ready),
    .seq_id_o (seq_id), .seq_class_o (seq_class),
    .seq_vd_o (seq_vd), .seq_vs1_o (seq_vs1), .seq_vs2_o (seq_vs2),
    .seq_src_kind_o (seq_src), .seq_vm_o (seq_vm), .seq_reads_vd_o (seq_rvd),
    .usage_o (usage)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference rules

  function automatic logic is_vector(input insn_t insn);
    logic [2:0] f3;
    f3 = insn[14:12];
    if (insn[6:0] == OPC_OP_V) return 1'b1;
    if (insn[6:0] == OPC_LOAD_FP || insn[6:0] == OPC_STORE_FP)
      return (f3 == 3'b000) || (f3 >= 3'b101);
    return 1'b0;
  endfunction

  function automatic logic owes_scalar(input insn_t insn);
    logic [2:0] f3;
    f3 = insn[14:12];
    return (insn[6:0] == OPC_OP_V) &&
           ((f3 == 3'b111) || (f3 == 3'b010 && insn[31:26] == 6'b010000));
  endfunction

  function automatic entry_t decode_entry(input insn_t insn, input insn_id_t id);
    entry_t     e;
    logic [2:0] f3;
    f3    = insn[14:12];
    e.id  = id;
    e.cls = CLS_ARITH;
    if (insn[6:0] == OPC_LOAD_FP) e.cls = CLS_LOAD;
    if (insn[6:0] == OPC_STORE_FP) e.cls = CLS_STORE;
    if (insn[6:0] == OPC_OP_V && f3 == 3'b111) e.cls = CLS_CFG;
    e.vd  = insn[11:7];
    e.vs1 = insn[19:15];
    e.vs2 = insn[24:20];
    e.vm  = insn[25];
    if (f3 == 3'b011) e.src = SRC_IMM;
    else if (f3 == 3'b111) e.src = SRC_NONE;
    else if (f3[2]) e.src = SRC_SCALAR;
    else e.src = SRC_VEC;
    // Multiply-add under the OPM and OPF categories, or store data
    e.rvd = (insn[31:29] == 3'b101 && (f3[1] ^ f3[0])) || (insn[6:0] == OPC_STORE_FP);
    return e;
  endfunction

  // Kind 0 OP-V, 1 LOAD-FP, 2 STORE-FP, 3 any other opcode
  function automatic insn_t random_insn(input int kind, input int idx);
    insn_t      insn;
    logic [6:0] opc;
    insn        = $urandom;
    opc         = 7'($urandom);
    insn[14:12] = 3'(idx);
    if (opc == OPC_OP_V || opc == OPC_LOAD_FP || opc == OPC_STORE_FP) opc = opc ^ 7'h10;
    case (kind)
      0: insn[6:0] = OPC_OP_V;
      1: insn[6:0] = OPC_LOAD_FP;
      2: insn[6:0] = OPC_STORE_FP;
      default: insn[6:0] = opc;
    endcase
    if (kind == 0 && idx % 4 == 2) insn[31:26] = 6'b010000;
    return insn;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Cycle driver and checks

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  // Samples at the falling edge, drives 1 ns after the next rising edge
  task automatic tick();
    entry_t head;
    @(negedge clk);
    s_ready = issue_ready;
    s_valid = seq_valid;
    s_usage = usage;
    xfer    = issue_valid && issue_ready;
    compare("issue_ready_o", 32'(issue_valid && model_q.size() < DEPTH && !flush),
            32'(issue_ready));
    compare("seq_valid_o", 32'(model_q.size() != 0), 32'(seq_valid));
    compare("usage_o", 32'(model_q.size()), 32'(usage));
    if (seq_valid && model_q.size() != 0) begin
      head = model_q[0];
      compare("seq_id_o", 32'(head.id), 32'(seq_id));
      compare("seq_class_o", 32'(head.cls), 32'(seq_class));
      compare("seq_vd_o", 32'(head.vd), 32'(seq_vd));
      compare("seq_vs1_o", 32'(head.vs1), 32'(seq_vs1));
      compare("seq_vs2_o", 32'(head.vs2), 32'(seq_vs2));
      compare("seq_src_kind_o", 32'(head.src), 32'(seq_src));
      compare("seq_vm_o", 32'(head.vm), 32'(seq_vm));
      compare("seq_reads_vd_o", 32'(head.rvd), 32'(seq_rvd));
      if (seq_ready) void'(model_q.pop_front());
    end
    if (issue_valid) begin
      compare("issue_accept_o", 32'(is_vector(issue_instr)), 32'(issue_accept));
      compare("issue_writeback_o", 32'(owes_scalar(issue_instr)), 32'(issue_wb));
      if (xfer && is_vector(issue_instr))
        model_q.push_back(decode_entry(issue_instr, issue_id));
    end
    if (flush) model_q.delete();
    @(posedge clk);
    #1;
    if (rand_ready) seq_ready = 1'($urandom);
  endtask

  // Holds the offer until the handshake completes
  task automatic offer(input insn_t insn, input insn_id_t id);
    issue_valid = 1'b1;
    issue_instr = insn;
    issue_id    = id;
    do begin
      tick();
    end while (!xfer);
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    rand_ready = 1'b0;
    seq_ready  = 1'b1;
    while (model_q.size() != 0) tick();
    tick();
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("Test %0d %s finished, %0d errors", tests, name, errors - base_errors);
    base_errors = errors;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Tests

  initial begin
    int i;
    void'($urandom(26));
    {rst_n, flush, issue_valid, seq_ready, rand_ready} = '0;
    issue_instr = '0;
    issue_id    = '0;
    {errors, checks, tests, base_errors} = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    tick();
    report_test("reset state");

    // Every width for every kind
    seq_ready = 1'b1;
    for (i = 0; i < N_CLS; i++) offer(random_insn(i % 4, i / 4), insn_id_t'(i));
    drain();
    report_test("classification");

    rand_ready = 1'b1;
    for (i = 0; i < N_ORD; i++)
      offer(random_insn($urandom_range(0, 2), $urandom_range(0, 7)), insn_id_t'($urandom));
    drain();
    report_test("ordering and fields");

    rand_ready = 1'b1;
    for (i = 0; i < N_REJ; i++) offer(random_insn((i % 2) * 3, i), insn_id_t'(i));
    drain();
    report_test("rejected offers");

    seq_ready = 1'b0;
    for (i = 0; i < DEPTH; i++) offer(random_insn(0, i), insn_id_t'(i));
    issue_valid = 1'b1;
    issue_instr = random_insn(0, 1);
    issue_id    = '1;
    tick();
    compare("usage_o", DEPTH, 32'(s_usage));
    compare("issue_ready_o", 0, 32'(s_ready));
    seq_ready = 1'b1;
    tick();
    seq_ready = 1'b0;
    tick();
    compare("issue_ready_o", 1, 32'(s_ready));
    issue_valid = 1'b0;
    drain();
    report_test("back-pressure");

    // Offer held across the flush cycle
    seq_ready = 1'b0;
    for (i = 0; i < 5; i++) offer(random_insn(0, i), insn_id_t'(i));
    issue_valid = 1'b1;
    issue_instr = random_insn(0, 3);
    issue_id    = 4'd9;
    flush       = 1'b1;
    tick();
    flush = 1'b0;
    tick();
    issue_valid = 1'b0;
    compare("seq_valid_o", 0, 32'(s_valid));
    compare("usage_o", 0, 32'(s_usage));
    rand_ready = 1'b1;
    for (i = 0; i < 4; i++) offer(random_insn(0, i + 4), insn_id_t'(i + 10));
    drain();
    report_test("flush");

    errors = errors + int'(uut.i_chk.fail_cnt);
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vec_issue_top.f ====
+incdir+hw
hw/vec_isa_pkg.sv
hw/vec_issue_pkg.sv
hw/vec_insn_classifier.sv
hw/vec_pre_decoder.sv
hw/vec_issue_queue.sv
hw/vec_issue_top.sv
tb/vec_issue_chk.sv
tb/tb_vec_issue_top.sv

// ==== Makefile ====
TOP := tb_vec_issue_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vec_issue_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vec_issue_top.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
